// ==== all.f ====
rt_bus_pkg.sv
rt_map_pkg.sv
rt_axil_slave.sv
log_capture.sv
entropy_feed.sv
rt_reg_file.sv
fpga_rt_top.sv
tb_fpga_rt.sv

// ==== rt_stim.txt ====
// test  op  addr/count  data  expected   (all hex)
// op 1 write, 2 read, 3 log push, 4 nibbles, 5 quiet, 6 cycle count, 7 masked read, 8 log drain
1 2 04 00000001 00000000
1 2 0C 00000001 00000000
1 2 10 00000000 00000000
2 1 10 00000037 00000000
2 2 10 00000037 00000000
2 2 40 00000000 00000002
2 6 14 00000000 00000000
2 1 10 00000000 00000000
3 3 03 00000041 00000000
3 8 03 00000141 00000000
3 7 00 00000100 00000000
3 3 11 00000050 00000000
3 2 04 00000002 00000000
3 8 10 00000150 00000000
3 7 00 00000100 00000000
4 1 08 9E3779B9 00000000
4 4 08 9E3779B9 00000001
4 2 0C 00000001 00000000
5 1 10 00000003 00000000
5 1 08 1F2E3D4C 00000000
5 4 02 1F2E3D4C 00000004
5 1 0C 00000004 00000000
5 2 0C 00000001 00000000
5 5 20 00000000 00000000
6 1 10 00000000 00000000
6 1 08 01234567 00000000
6 1 08 89ABCDEF 00000000
6 1 08 DEADBEEF 00000000
6 1 08 C0FFEE11 00000000
6 2 0C 00000002 00000000
6 1 08 55AA55AA 00000000
6 4 08 01234567 00000001
6 4 08 89ABCDEF 00000001
6 4 08 DEADBEEF 00000001
6 4 08 C0FFEE11 00000001
6 5 10 00000000 00000000
6 2 0C 00000001 00000000
0 F 00 00000000 00000000

// ==== tb_fpga_rt.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench for the real-time register wrapper
// Replays bus, log and entropy operations from a stimulus table and
// checks responses, log characters and nibble sequences
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps

module tb_fpga_rt
    import rt_bus_pkg::*;
    import rt_map_pkg::*;
();

    localparam int STIM_ENTRIES = 38;
    localparam int STIM_WORDS   = STIM_ENTRIES * 5;
    localparam int TIMEOUT      = 200;

    // Stimulus opcodes
    localparam logic [31:0] OP_WRITE       = 32'h1;
    localparam logic [31:0] OP_READ        = 32'h2;
    localparam logic [31:0] OP_PUSH_LOG    = 32'h3;
    localparam logic [31:0] OP_NIBBLES     = 32'h4;
    localparam logic [31:0] OP_QUIET       = 32'h5;
    localparam logic [31:0] OP_CYCLES      = 32'h6;
    localparam logic [31:0] OP_READ_MASKED = 32'h7;
    localparam logic [31:0] OP_DRAIN       = 32'h8;
    localparam logic [31:0] OP_END         = 32'hF;

    logic        core_clk;
    logic        hwif_out;
    axil_req_t   axil_req;
    axil_rsp_t   axil_rsp;
    log_char_t   log_char;
    logic        log_char_valid;
    logic        etrng_req;
    nibble_t     itrng_data;
    logic        itrng_valid;

    logic [31:0] stim [0:STIM_WORDS-1];
    int          errors;
    int          checks;
    int          tests;
    int          test_errors;
    logic [31:0] cur_test;
    bit          timed_out;

    fpga_rt_top u_fpga_rt_top (
        .core_clk       (core_clk),
        .hwif_out       (hwif_out),
        .axil_req       (axil_req),
        .log_char       (log_char),
        .log_char_valid (log_char_valid),
        .etrng_req      (etrng_req),
        .axil_rsp       (axil_rsp),
        .itrng_data     (itrng_data),
        .itrng_valid    (itrng_valid)
    );

    always begin
        #4 core_clk = ~core_clk;
    end

    // Every step ends 1 ns after a rising edge
    task automatic next_cycle();
        @(posedge core_clk);
        #1;
    endtask

    task automatic compare_value(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            $display("ERR test %0d: %s expected %h got %h", cur_test, name, exp, got);
            errors++;
            test_errors++;
        end
    endtask

    task automatic report_timeout(input string what);
        $display("Test %0d: timed out waiting for %s", cur_test, what);
        errors++;
        test_errors++;
        timed_out = 1'b1;
    endtask

    task automatic bus_write(input axil_addr_t addr, input axil_data_t data,
                             output axil_resp_t resp);
        int wait_cnt;
        wait_cnt = 0;
        resp = RESP_OKAY;
        axil_req.awvalid = 1'b1;
        axil_req.awaddr  = addr;
        axil_req.wvalid  = 1'b1;
        axil_req.wdata   = data;
        #1;
        while (!(axil_rsp.awready && axil_rsp.wready) && wait_cnt < TIMEOUT) begin
            next_cycle();
            #1;
            wait_cnt++;
        end
        if (!(axil_rsp.awready && axil_rsp.wready)) begin
            report_timeout("write address and data acceptance");
            return;
        end
        next_cycle();
        axil_req.awvalid = 1'b0;
        axil_req.wvalid  = 1'b0;
        wait_cnt = 0;
        while (!axil_rsp.bvalid && wait_cnt < TIMEOUT) begin
            next_cycle();
            wait_cnt++;
        end
        if (!axil_rsp.bvalid) begin
            report_timeout("write response");
            return;
        end
        resp = axil_rsp.bresp;
        // bready is held high, so the response leaves at this edge
        next_cycle();
    endtask

    task automatic bus_read(input axil_addr_t addr, output axil_data_t data,
                            output axil_resp_t resp);
        int wait_cnt;
        wait_cnt = 0;
        data = '0;
        resp = RESP_OKAY;
        axil_req.arvalid = 1'b1;
        axil_req.araddr  = addr;
        #1;
        while (!axil_rsp.arready && wait_cnt < TIMEOUT) begin
            next_cycle();
            #1;
            wait_cnt++;
        end
        if (!axil_rsp.arready) begin
            report_timeout("read address acceptance");
            return;
        end
        next_cycle();
        axil_req.arvalid = 1'b0;
        wait_cnt = 0;
        while (!axil_rsp.rvalid && wait_cnt < TIMEOUT) begin
            next_cycle();
            wait_cnt++;
        end
        if (!axil_rsp.rvalid) begin
            report_timeout("read data");
            return;
        end
        data = axil_rsp.rdata;
        resp = axil_rsp.rresp;
        next_cycle();
    endtask

    // Characters count up from the first one, one push per cycle
    task automatic push_chars(input int count, input log_char_t first);
        for (int i = 0; i < count; i++) begin
            log_char       = log_char_t'(first + i);
            log_char_valid = 1'b1;
            next_cycle();
        end
        log_char_valid = 1'b0;
    endtask

    task automatic collect_nibbles(input int count, input logic [31:0] word,
                                   input int min_gap);
        int gap;
        etrng_req = 1'b1;
        for (int i = 0; i < count; i++) begin
            gap = 0;
            next_cycle();
            gap++;
            while (!itrng_valid && gap < TIMEOUT) begin
                next_cycle();
                gap++;
            end
            if (!itrng_valid) begin
                report_timeout("an entropy nibble");
                etrng_req = 1'b0;
                return;
            end
            compare_value("itrng_data", 32'(itrng_data), 32'(word[4*i +: 4]));
            checks++;
            if (i > 0 && gap < min_gap) begin
                $display("Test %0d: nibble %0d came %0d cycles after the previous one",
                         cur_test, i, gap);
                errors++;
                test_errors++;
            end
        end
        etrng_req = 1'b0;
    endtask

    // Request held high while no nibble may show up
    task automatic watch_quiet(input int count);
        etrng_req = 1'b1;
        for (int i = 0; i < count; i++) begin
            next_cycle();
            checks++;
            if (itrng_valid) begin
                $display("Test %0d: unexpected nibble %h on an empty feed",
                         cur_test, itrng_data);
                errors++;
                test_errors++;
            end
        end
        etrng_req = 1'b0;
    endtask

    task automatic close_test();
        tests++;
        $display("Test %0d done, %0d errors", cur_test, test_errors);
        test_errors = 0;
    endtask

    initial begin
        int          idx;
        logic [31:0] op;
        logic [31:0] arg;
        logic [31:0] data;
        logic [31:0] exp;
        axil_data_t  rd_data;
        axil_data_t  first_count;
        axil_resp_t  resp;

        core_clk       = 1'b0;
        hwif_out       = 1'b0;
        axil_req       = '0;
        log_char       = '0;
        log_char_valid = 1'b0;
        etrng_req      = 1'b0;
        errors         = 0;
        checks         = 0;
        tests          = 0;
        test_errors    = 0;
        cur_test       = '0;
        timed_out      = 1'b0;
        $readmemh("rt_stim.txt", stim);

        repeat (10) @(posedge core_clk);
        #1;
        hwif_out       = 1'b1;
        axil_req.bready = 1'b1;
        axil_req.rready = 1'b1;
        next_cycle();

        idx = 0;
        while (!timed_out && idx + 4 < STIM_WORDS && stim[idx+1] !== OP_END) begin
            if (stim[idx] !== cur_test) begin
                if (cur_test != 0) begin
                    close_test();
                end
                cur_test = stim[idx];
            end
            op   = stim[idx+1];
            arg  = stim[idx+2];
            data = stim[idx+3];
            exp  = stim[idx+4];
            case (op)
                OP_WRITE: begin
                    bus_write(arg[7:0], data, resp);
                    if (!timed_out) begin
                        compare_value("bresp", 32'(resp), exp);
                    end
                end
                OP_READ: begin
                    bus_read(arg[7:0], rd_data, resp);
                    if (!timed_out) begin
                        compare_value("rdata", rd_data, data);
                        compare_value("rresp", 32'(resp), exp);
                    end
                end
                OP_READ_MASKED: begin
                    bus_read(arg[7:0], rd_data, resp);
                    if (!timed_out) begin
                        compare_value("rdata masked", rd_data & data, exp);
                        compare_value("rresp", 32'(resp), 32'(RESP_OKAY));
                    end
                end
                OP_DRAIN: begin
                    for (int i = 0; i < arg && !timed_out; i++) begin
                        bus_read(REG_LOG_DATA, rd_data, resp);
                        if (!timed_out) begin
                            compare_value("rdata", rd_data, data + i);
                            compare_value("rresp", 32'(resp), 32'(RESP_OKAY));
                        end
                    end
                end
                OP_PUSH_LOG: push_chars(arg, data[7:0]);
                OP_NIBBLES:  collect_nibbles(arg, data, exp);
                OP_QUIET:    watch_quiet(arg);
                OP_CYCLES: begin
                    bus_read(arg[7:0], first_count, resp);
                    if (!timed_out) begin
                        bus_read(arg[7:0], rd_data, resp);
                    end
                    if (!timed_out) begin
                        checks++;
                        if (!(rd_data > first_count)) begin
                            $display("Test %0d: cycle count did not increase, %h then %h",
                                     cur_test, first_count, rd_data);
                            errors++;
                            test_errors++;
                        end
                    end
                end
                default: begin
                    $display("Test %0d: unknown opcode %h in the stimulus table", cur_test, op);
                    errors++;
                    test_errors++;
                end
            endcase
            idx += 5;
        end
        if (cur_test != 0) begin
            close_test();
        end

        $display("Tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0 && !timed_out) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

// ==== fpga_rt_top.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Real-time register wrapper beside the security core
// Host AXI4-Lite slave, debug log FIFO, entropy feed and cycle counter
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps

module fpga_rt_top
    import rt_bus_pkg::*;
    import rt_map_pkg::*;
(
    input  logic      core_clk,
    input  logic      hwif_out,
    input  axil_req_t axil_req,
    input  log_char_t log_char,
    input  logic      log_char_valid,
    input  logic      etrng_req,
    output axil_rsp_t axil_rsp,
    output nibble_t   itrng_data,
    output logic      itrng_valid
);

    logic       reg_wr;
    logic       reg_rd;
    axil_addr_t reg_addr;
    axil_data_t reg_wdata;
    axil_data_t reg_rdata;
    logic       reg_err;
    log_char_t  log_head;
    logic       log_empty;
    logic       log_full;
    logic       log_pop;
    logic       word_push;
    axil_data_t word_data;
    logic       flush;
    divisor_t   divisor;
    logic       itrng_empty;
    logic       itrng_full;

    rt_axil_slave u_rt_axil_slave (
        .core_clk  (core_clk),
        .hwif_out  (hwif_out),
        .axil_req  (axil_req),
        .reg_rdata (reg_rdata),
        .reg_err   (reg_err),
        .axil_rsp  (axil_rsp),
        .reg_wr    (reg_wr),
        .reg_rd    (reg_rd),
        .reg_addr  (reg_addr),
        .reg_wdata (reg_wdata)
    );

    rt_reg_file u_rt_reg_file (
        .core_clk    (core_clk),
        .hwif_out    (hwif_out),
        .reg_wr      (reg_wr),
        .reg_rd      (reg_rd),
        .reg_addr    (reg_addr),
        .reg_wdata   (reg_wdata),
        .log_head    (log_head),
        .log_empty   (log_empty),
        .log_full    (log_full),
        .itrng_empty (itrng_empty),
        .itrng_full  (itrng_full),
        .reg_rdata   (reg_rdata),
        .reg_err     (reg_err),
        .log_pop     (log_pop),
        .word_push   (word_push),
        .word_data   (word_data),
        .flush       (flush),
        .divisor     (divisor)
    );

    // Log capture and entropy feed run side by side
    log_capture u_log_capture (
        .core_clk       (core_clk),
        .hwif_out       (hwif_out),
        .log_char       (log_char),
        .log_char_valid (log_char_valid),
        .log_pop        (log_pop),
        .log_head       (log_head),
        .log_empty      (log_empty),
        .log_full       (log_full)
    );

    entropy_feed u_entropy_feed (
        .core_clk    (core_clk),
        .hwif_out    (hwif_out),
        .word_push   (word_push),
        .word_data   (word_data),
        .flush       (flush),
        .divisor     (divisor),
        .etrng_req   (etrng_req),
        .itrng_data  (itrng_data),
        .itrng_valid (itrng_valid),
        .itrng_empty (itrng_empty),
        .itrng_full  (itrng_full)
    );

endmodule

// ==== rt_reg_file.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Real-time register file
// Offset decode, divisor and cycle counter, host read view of both FIFOs
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps

module rt_reg_file
    import rt_bus_pkg::*;
    import rt_map_pkg::*;
(
    input  logic       core_clk,
    input  logic       hwif_out,
    input  logic       reg_wr,
    input  logic       reg_rd,
    input  axil_addr_t reg_addr,
    input  axil_data_t reg_wdata,
    input  log_char_t  log_head,
    input  logic       log_empty,
    input  logic       log_full,
    input  logic       itrng_empty,
    input  logic       itrng_full,
    output axil_data_t reg_rdata,
    output logic       reg_err,
    output logic       log_pop,
    output logic       word_push,
    output axil_data_t word_data,
    output logic       flush,
    output divisor_t   divisor
);

    divisor_t   divisor_q;
    axil_data_t cycle_q;

    assign log_pop   = reg_rd && (reg_addr == REG_LOG_DATA);
    assign word_push = reg_wr && (reg_addr == REG_ITRNG_DATA);
    assign word_data = reg_wdata;
    assign flush     = reg_wr && (reg_addr == REG_ITRNG_STATUS) && reg_wdata[ITRNG_FLUSH_BIT];
    assign divisor   = divisor_q;

    always_ff @(posedge core_clk or negedge hwif_out) begin
        if (!hwif_out) begin
            divisor_q <= '0;
            cycle_q   <= '0;
        end else begin
            cycle_q <= cycle_q + 1'b1;
            if (reg_wr && (reg_addr == REG_ITRNG_DIVISOR)) begin
                divisor_q <= reg_wdata;
            end
        end
    end

    // Read view; valid bit of the log word mirrors a non-empty FIFO
    always_comb begin
        reg_err = 1'b0;
        case (reg_addr)
            REG_LOG_DATA:      reg_rdata = {23'b0, ~log_empty, log_head};
            REG_LOG_STATUS:    reg_rdata = {30'b0, log_full, log_empty};
            REG_ITRNG_DATA:    reg_rdata = '0;
            REG_ITRNG_STATUS:  reg_rdata = {30'b0, itrng_full, itrng_empty};
            REG_ITRNG_DIVISOR: reg_rdata = divisor_q;
            REG_CYCLE_COUNT:   reg_rdata = cycle_q;
            default: begin
                reg_rdata = '0;
                reg_err   = 1'b1;
            end
        endcase
    end

endmodule

// ==== entropy_feed.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Entropy feed toward the core
// Host words are queued, then handed out one nibble per throttled grant,
// low nibble first
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps

module entropy_feed
    import rt_bus_pkg::*;
    import rt_map_pkg::*;
(
    input  logic       core_clk,
    input  logic       hwif_out,
    input  logic       word_push,
    input  axil_data_t word_data,
    input  logic       flush,
    input  divisor_t   divisor,
    input  logic       etrng_req,
    output nibble_t    itrng_data,
    output logic       itrng_valid,
    output logic       itrng_empty,
    output logic       itrng_full
);

    axil_data_t             mem [ITRNG_DEPTH];
    logic [ITRNG_PTR_W-1:0] wr_ptr;
    logic [ITRNG_PTR_W-1:0] rd_ptr;
    logic [ITRNG_PTR_W:0]   count;
    logic [NIB_IDX_W-1:0]   nib_idx;
    divisor_t               throttle_q;
    logic                   grant;
    logic                   push_ok;
    logic                   pop_ok;

    assign itrng_empty = (count == 0);
    assign itrng_full  = (count == ITRNG_DEPTH);
    assign push_ok     = word_push && !itrng_full && !flush;

    // One nibble per permitted slot, none while flushing
    assign grant  = (throttle_q == 0) && etrng_req && !itrng_empty && !flush;
    assign pop_ok = grant && (nib_idx == NIB_IDX_W'(NIBBLES_PER_WORD - 1));

    // Throttle runs regardless of requests
    always_ff @(posedge core_clk or negedge hwif_out) begin
        if (!hwif_out) begin
            throttle_q <= '0;
        end else if (throttle_q == 0) begin
            throttle_q <= divisor;
        end else begin
            throttle_q <= throttle_q - 1'b1;
        end
    end

    always_ff @(posedge core_clk or negedge hwif_out) begin
        if (!hwif_out) begin
            wr_ptr      <= '0;
            rd_ptr      <= '0;
            count       <= '0;
            nib_idx     <= '0;
            itrng_valid <= 1'b0;
        end else if (flush) begin
            rd_ptr      <= wr_ptr;
            count       <= '0;
            nib_idx     <= '0;
            itrng_valid <= 1'b0;
        end else begin
            itrng_valid <= grant;
            if (grant) begin
                nib_idx <= nib_idx + 1'b1;
            end
            if (push_ok) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop_ok) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            if (push_ok && !pop_ok) begin
                count <= count + 1'b1;
            end else if (pop_ok && !push_ok) begin
                count <= count - 1'b1;
            end
        end
    end

    always_ff @(posedge core_clk) begin
        if (push_ok) begin
            mem[wr_ptr] <= word_data;
        end
        if (grant) begin
            itrng_data <= mem[rd_ptr][nib_idx * $bits(nibble_t) +: $bits(nibble_t)];
        end
    end

    a_valid_after_grant: assert property (@(posedge core_clk) disable iff (!hwif_out)
        itrng_valid |-> $past(grant));

endmodule

// ==== log_capture.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Debug log FIFO
// Captures characters from the core, drained by host reads
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps

module log_capture
    import rt_map_pkg::*;
(
    input  logic      core_clk,
    input  logic      hwif_out,
    input  log_char_t log_char,
    input  logic      log_char_valid,
    input  logic      log_pop,
    output log_char_t log_head,
    output logic      log_empty,
    output logic      log_full
);

    log_char_t            mem [LOG_DEPTH];
    logic [LOG_PTR_W-1:0] wr_ptr;
    logic [LOG_PTR_W-1:0] rd_ptr;
    logic [LOG_PTR_W:0]   count;
    logic                 push_ok;
    logic                 pop_ok;

    assign log_empty = (count == 0);
    assign log_full  = (count == LOG_DEPTH);
    // Full drops the character, empty ignores the pop
    assign push_ok   = log_char_valid && !log_full;
    assign pop_ok    = log_pop && !log_empty;
    assign log_head  = mem[rd_ptr];

    always_ff @(posedge core_clk or negedge hwif_out) begin
        if (!hwif_out) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push_ok) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop_ok) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            if (push_ok && !pop_ok) begin
                count <= count + 1'b1;
            end else if (pop_ok && !push_ok) begin
                count <= count - 1'b1;
            end
        end
    end

    always_ff @(posedge core_clk) begin
        if (push_ok) begin
            mem[wr_ptr] <= log_char;
        end
    end

    a_count_bound: assert property (@(posedge core_clk) disable iff (!hwif_out)
        count <= LOG_DEPTH);

endmodule

// ==== rt_axil_slave.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// AXI4-Lite slave for the real-time register block
// Accepts one write or read at a time, issues a single-cycle register
// strobe and holds the registered response until the host takes it
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps

module rt_axil_slave
    import rt_bus_pkg::*;
    import rt_map_pkg::*;
(
    input  logic       core_clk,
    input  logic       hwif_out,
    input  axil_req_t  axil_req,
    input  axil_data_t reg_rdata,
    input  logic       reg_err,
    output axil_rsp_t  axil_rsp,
    output logic       reg_wr,
    output logic       reg_rd,
    output axil_addr_t reg_addr,
    output axil_data_t reg_wdata
);

    slave_state_t state_q;
    slave_state_t state_d;
    axil_resp_t   bresp_q;
    axil_resp_t   rresp_q;
    axil_data_t   rdata_q;
    logic         wr_pending;

    // Any write channel activity blocks a read
    assign wr_pending = axil_req.awvalid || axil_req.wvalid;

    assign reg_wr    = (state_q == S_IDLE) && axil_req.awvalid && axil_req.wvalid;
    assign reg_rd    = (state_q == S_IDLE) && axil_req.arvalid && !wr_pending;
    assign reg_addr  = reg_wr ? axil_req.awaddr : axil_req.araddr;
    assign reg_wdata = axil_req.wdata;

    always_comb begin
        state_d = state_q;
        case (state_q)
            S_IDLE: begin
                if (reg_wr) begin
                    state_d = S_WRESP;
                end else if (reg_rd) begin
                    state_d = S_RRESP;
                end
            end
            S_WRESP: begin
                if (axil_req.bready) begin
                    state_d = S_IDLE;
                end
            end
            S_RRESP: begin
                if (axil_req.rready) begin
                    state_d = S_IDLE;
                end
            end
            default: state_d = S_IDLE;
        endcase
    end

    always_ff @(posedge core_clk or negedge hwif_out) begin
        if (!hwif_out) begin
            state_q <= S_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // Response payload, captured in the acceptance cycle
    always_ff @(posedge core_clk) begin
        if (reg_wr) begin
            bresp_q <= reg_err ? RESP_SLVERR : RESP_OKAY;
        end
        if (reg_rd) begin
            rdata_q <= reg_rdata;
            rresp_q <= reg_err ? RESP_SLVERR : RESP_OKAY;
        end
    end

    always_comb begin
        axil_rsp.awready = reg_wr;
        axil_rsp.wready  = reg_wr;
        axil_rsp.bvalid  = (state_q == S_WRESP);
        axil_rsp.bresp   = bresp_q;
        axil_rsp.arready = reg_rd;
        axil_rsp.rvalid  = (state_q == S_RRESP);
        axil_rsp.rdata   = rdata_q;
        axil_rsp.rresp   = rresp_q;
    end

    a_bvalid_hold: assert property (@(posedge core_clk) disable iff (!hwif_out)
        axil_rsp.bvalid && !axil_req.bready |=> axil_rsp.bvalid && $stable(axil_rsp.bresp));

    a_rvalid_hold: assert property (@(posedge core_clk) disable iff (!hwif_out)
        axil_rsp.rvalid && !axil_req.rready |=> axil_rsp.rvalid && $stable(axil_rsp.rdata));

    a_single_strobe: assert property (@(posedge core_clk) disable iff (!hwif_out)
        !(reg_wr && reg_rd));

endmodule

// ==== rt_map_pkg.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Register map and FIFO geometry of the real-time wrapper
// Offsets, depths, log and entropy data types, slave FSM states
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package rt_map_pkg;

    typedef logic [7:0]  log_char_t;
    typedef logic [3:0]  nibble_t;
    typedef logic [31:0] divisor_t;

    // Register offsets, byte addressed
    localparam logic [7:0] REG_LOG_DATA      = 8'h00;
    localparam logic [7:0] REG_LOG_STATUS    = 8'h04;
    localparam logic [7:0] REG_ITRNG_DATA    = 8'h08;
    localparam logic [7:0] REG_ITRNG_STATUS  = 8'h0C;
    localparam logic [7:0] REG_ITRNG_DIVISOR = 8'h10;
    localparam logic [7:0] REG_CYCLE_COUNT   = 8'h14;

    // Write-one flush bit in REG_ITRNG_STATUS
    localparam int ITRNG_FLUSH_BIT = 2;

    localparam int LOG_DEPTH        = 16;
    localparam int ITRNG_DEPTH      = 4;
    localparam int NIBBLES_PER_WORD = 8;

    // Derived pointer widths
    localparam int LOG_PTR_W   = $clog2(LOG_DEPTH);
    localparam int ITRNG_PTR_W = $clog2(ITRNG_DEPTH);
    localparam int NIB_IDX_W   = $clog2(NIBBLES_PER_WORD);

    typedef enum logic [1:0] {
        S_IDLE,
        S_WRESP,
        S_RRESP
    } slave_state_t;

endpackage

// ==== rt_bus_pkg.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Host bus definitions for the real-time register wrapper
// AXI4-Lite request and response bundles, word and address types
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package rt_bus_pkg;

    // Only the low address byte is decoded
    typedef logic [7:0]  axil_addr_t;
    typedef logic [31:0] axil_data_t;
    typedef logic [1:0]  axil_resp_t;

    localparam axil_resp_t RESP_OKAY   = 2'b00;
    localparam axil_resp_t RESP_SLVERR = 2'b10;

    // Host side of the bus
    typedef struct packed {
        logic       awvalid;
        axil_addr_t awaddr;
        logic       wvalid;
        axil_data_t wdata;
        logic       bready;
        logic       arvalid;
        axil_addr_t araddr;
        logic       rready;
    } axil_req_t;

    // Slave side of the bus
    typedef struct packed {
        logic       awready;
        logic       wready;
        logic       bvalid;
        axil_resp_t bresp;
        logic       arready;
        logic       rvalid;
        axil_data_t rdata;
        axil_resp_t rresp;
    } axil_rsp_t;

endpackage
